/* build.f */
+incdir+common
common/dma_chain_pkg.sv
hw/dma_prg/dma_prg_reg.sv
hw/dma_prg/dma_ctrl_regs.sv
hw/desc_walk/dma_desc_walker.sv
hw/dma_chain_top.sv
sim/dma_chain_props.sv
sim/dma_chain_tb.sv

/* common/dma_chain_consts.svh */
// Register map, DW0 field positions and the clear pattern of the DMA header tables
// Included by the header registers, the register bank and the descriptor walker
`ifndef DMA_CHAIN_CONSTS_SVH
`define DMA_CHAIN_CONSTS_SVH

// ------------------------------------------------------------
// Address map
// ------------------------------------------------------------
// One descriptor in root complex memory, used as the fetch stride
`define DMA_DESC_BYTES 16
// Address bit 4 picks the read table, bits 3:2 pick the header word
`define DMA_DIR_BIT 4

// ------------------------------------------------------------
// DW0 fields
// ------------------------------------------------------------
// Size sits in bits 15:0
`define DMA_DW0_MSI_BIT 17
`define DMA_DW0_EPLAST_BIT 18
// MSI number is 5 bits wide, traffic class is 3 bits wide
`define DMA_DW0_MSINUM_LSB 20
`define DMA_DW0_TC_LSB 28
// Restart from descriptor zero when the table end is passed
`define DMA_DW0_SYNC_BIT 31

// Low half of a DW0 write that clears the table
`define DMA_CLEAR_PATTERN 16'hFFFF

`endif

/* common/dma_chain_pkg.sv */
// Types shared by the DMA header registers, the descriptor walker and the testbench
// Pulled in by a wildcard import in each module header
`default_nettype none

package dma_chain_pkg;

   // Header word index, taken from register address bits 3:2
   typedef enum logic [1:0] {
      HDR_DW0 = 2'd0,
      HDR_DW1 = 2'd1,
      HDR_DW2 = 2'd2,
      HDR_DW3 = 2'd3
   } hdr_word_t;

   // Descriptor walker FSM
   typedef enum logic [1:0] {
      // Waiting for init to fall or for rc_last to move
      WALK_IDLE   = 2'd0,
      // One cycle, desc_req is high
      WALK_REQ    = 2'd1,
      // Fetch outstanding until desc_done
      WALK_WAIT   = 2'd2,
      // eplast and MSI strobes, then next index
      WALK_REPORT = 2'd3
   } walk_state_t;

endpackage

`default_nettype wire

/* hw/desc_walk/dma_desc_walker.sv */
// Descriptor walker for one DMA direction
// Turns the programmed header into fetch requests, eplast updates and an MSI
`timescale 1ns/1ps
`default_nettype none
`include "dma_chain_consts.svh"

module dma_desc_walker
   import dma_chain_pkg::*;
(
   input  logic        clk_in,
   input  logic        soft_dma_reset,
   // Header fields from the register bank
   input  logic [15:0] dt_size,
   input  logic [63:0] dt_base_rc,
   input  logic [15:0] dt_rc_last,
   input  logic        dt_rc_last_sync,
   input  logic        dt_eplast_ena,
   input  logic        dt_msi,
   input  logic [4:0]  app_msi_num,
   input  logic [2:0]  app_msi_tc,
   input  logic        init,
   // Descriptor fetch
   output logic        desc_req,
   output logic [63:0] desc_addr,
   input  logic        desc_done,
   // Progress report
   output logic        eplast_upd,
   output logic [15:0] eplast_idx,
   output logic        msi_req,
   output logic [4:0]  msi_num,
   output logic [2:0]  msi_tc
);

   walk_state_t state;
   // Index of the descriptor being fetched or next to fetch
   logic [15:0] idx;
   // rc_last as last seen in idle
   logic [15:0] last_seen;
   // Table end passed without sync, only a restart resumes
   logic        halted;
   logic        init_q;
   logic        init_fall;
   logic        at_end;

   assign init_fall = init_q && !init;
   assign at_end    = (idx == dt_size);

   always_ff @(posedge clk_in) begin
      if (soft_dma_reset) begin
         init_q <= 1'b1;
      end else begin
         init_q <= init;
      end
   end

   // ------------------------------------------------------------
   // Walk FSM, held idle while the table is in init
   // ------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset || init) begin
         state     <= WALK_IDLE;
         idx       <= '0;
         last_seen <= '0;
         halted    <= 1'b0;
      end else begin
         case (state)
            WALK_IDLE: begin
               if (init_fall) begin
                  // Fresh table, walk from descriptor zero
                  idx       <= '0;
                  last_seen <= dt_rc_last;
                  state     <= WALK_REQ;
               end else if (dt_rc_last != last_seen) begin
                  last_seen <= dt_rc_last;
                  if (!halted && (dt_rc_last >= idx)) begin
                     // rc_last moved ahead, carry on
                     state <= WALK_REQ;
                  end else if (dt_rc_last_sync) begin
                     // Host wrapped around, restart at zero
                     idx    <= '0;
                     halted <= 1'b0;
                     state  <= WALK_REQ;
                  end
               end
            end
            WALK_REQ: begin
               state <= WALK_WAIT;
            end
            WALK_WAIT: begin
               // Single fetch outstanding
               if (desc_done) begin
                  state <= WALK_REPORT;
               end
            end
            WALK_REPORT: begin
               if (at_end && !dt_rc_last_sync) begin
                  halted <= 1'b1;
                  state  <= WALK_IDLE;
               end else begin
                  idx   <= at_end ? 16'd0 : idx + 16'd1;
                  state <= (idx == last_seen) ? WALK_IDLE : WALK_REQ;
               end
            end
            default: state <= WALK_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Strobes decoded from the state
   // ------------------------------------------------------------
   assign desc_req  = (state == WALK_REQ);
   // Base plus index times descriptor size
   assign desc_addr = dt_base_rc + (64'(idx) * 64'(`DMA_DESC_BYTES));

   assign eplast_upd = (state == WALK_REPORT) && dt_eplast_ena;
   assign eplast_idx = idx;

   // MSI only once the last valid descriptor is done
   assign msi_req = (state == WALK_REPORT) && dt_msi && (idx == last_seen);
   assign msi_num = app_msi_num;
   assign msi_tc  = app_msi_tc;

endmodule

`default_nettype wire

/* hw/dma_chain_top.sv */
// Chaining DMA control core, register bank plus one walker per direction
// The fetch, eplast and MSI strobes go to the TLP side of the endpoint
`timescale 1ns/1ps
`default_nettype none

module dma_chain_top (
   input  logic        clk_in,
   input  logic        soft_dma_reset,
   // Host register port
   input  logic        prg_wrena,
   input  logic [7:0]  prg_addr,
   input  logic [31:0] prg_wrdata,
   output logic [31:0] prg_rddata,
   // Table status
   output logic        init_wr,
   output logic        init_rd,
   output logic        dt_3dw_wr,
   output logic        dt_3dw_rd,
   // Write direction strobes
   output logic        desc_req_wr,
   output logic [63:0] desc_addr_wr,
   input  logic        desc_done_wr,
   output logic        eplast_upd_wr,
   output logic [15:0] eplast_idx_wr,
   output logic        msi_req_wr,
   output logic [4:0]  msi_num_wr,
   output logic [2:0]  msi_tc_wr,
   // Read direction strobes
   output logic        desc_req_rd,
   output logic [63:0] desc_addr_rd,
   input  logic        desc_done_rd,
   output logic        eplast_upd_rd,
   output logic [15:0] eplast_idx_rd,
   output logic        msi_req_rd,
   output logic [4:0]  msi_num_rd,
   output logic [2:0]  msi_tc_rd
);

   // Header fields, write direction
   logic [15:0] dt_size_wr;
   logic [63:0] dt_base_rc_wr;
   logic [15:0] dt_rc_last_wr;
   logic        dt_rc_last_sync_wr;
   logic        dt_eplast_ena_wr;
   logic        dt_msi_wr;
   logic [4:0]  app_msi_num_wr;
   logic [2:0]  app_msi_tc_wr;
   // Header fields, read direction
   logic [15:0] dt_size_rd;
   logic [63:0] dt_base_rc_rd;
   logic [15:0] dt_rc_last_rd;
   logic        dt_rc_last_sync_rd;
   logic        dt_eplast_ena_rd;
   logic        dt_msi_rd;
   logic [4:0]  app_msi_num_rd;
   logic [2:0]  app_msi_tc_rd;

   dma_ctrl_regs u_regs (
      .clk_in (clk_in), .soft_dma_reset (soft_dma_reset),
      .prg_wrena (prg_wrena), .prg_addr (prg_addr),
      .prg_wrdata (prg_wrdata), .prg_rddata (prg_rddata),
      .dt_size_wr (dt_size_wr), .dt_base_rc_wr (dt_base_rc_wr),
      .dt_rc_last_wr (dt_rc_last_wr), .dt_rc_last_sync_wr (dt_rc_last_sync_wr),
      .dt_eplast_ena_wr (dt_eplast_ena_wr), .dt_msi_wr (dt_msi_wr),
      .dt_3dw_rcadd_wr (dt_3dw_wr), .app_msi_num_wr (app_msi_num_wr),
      .app_msi_tc_wr (app_msi_tc_wr), .init_wr (init_wr),
      .dt_size_rd (dt_size_rd), .dt_base_rc_rd (dt_base_rc_rd),
      .dt_rc_last_rd (dt_rc_last_rd), .dt_rc_last_sync_rd (dt_rc_last_sync_rd),
      .dt_eplast_ena_rd (dt_eplast_ena_rd), .dt_msi_rd (dt_msi_rd),
      .dt_3dw_rcadd_rd (dt_3dw_rd), .app_msi_num_rd (app_msi_num_rd),
      .app_msi_tc_rd (app_msi_tc_rd), .init_rd (init_rd)
   );

   // ------------------------------------------------------------
   // One walker per direction
   // ------------------------------------------------------------
   dma_desc_walker u_walk_wr (
      .clk_in (clk_in), .soft_dma_reset (soft_dma_reset),
      .dt_size (dt_size_wr), .dt_base_rc (dt_base_rc_wr),
      .dt_rc_last (dt_rc_last_wr), .dt_rc_last_sync (dt_rc_last_sync_wr),
      .dt_eplast_ena (dt_eplast_ena_wr), .dt_msi (dt_msi_wr),
      .app_msi_num (app_msi_num_wr), .app_msi_tc (app_msi_tc_wr), .init (init_wr),
      .desc_req (desc_req_wr), .desc_addr (desc_addr_wr), .desc_done (desc_done_wr),
      .eplast_upd (eplast_upd_wr), .eplast_idx (eplast_idx_wr),
      .msi_req (msi_req_wr), .msi_num (msi_num_wr), .msi_tc (msi_tc_wr)
   );

   dma_desc_walker u_walk_rd (
      .clk_in (clk_in), .soft_dma_reset (soft_dma_reset),
      .dt_size (dt_size_rd), .dt_base_rc (dt_base_rc_rd),
      .dt_rc_last (dt_rc_last_rd), .dt_rc_last_sync (dt_rc_last_sync_rd),
      .dt_eplast_ena (dt_eplast_ena_rd), .dt_msi (dt_msi_rd),
      .app_msi_num (app_msi_num_rd), .app_msi_tc (app_msi_tc_rd), .init (init_rd),
      .desc_req (desc_req_rd), .desc_addr (desc_addr_rd), .desc_done (desc_done_rd),
      .eplast_upd (eplast_upd_rd), .eplast_idx (eplast_idx_rd),
      .msi_req (msi_req_rd), .msi_num (msi_num_rd), .msi_tc (msi_tc_rd)
   );

endmodule

`default_nettype wire

/* hw/dma_prg/dma_ctrl_regs.sv */
// Register bank with the write and read header tables behind one host port
// Decodes the direction bit for writes and selects the matching readback
`timescale 1ns/1ps
`default_nettype none
`include "dma_chain_consts.svh"

module dma_ctrl_regs
   import dma_chain_pkg::*;
(
   input  logic        clk_in,
   input  logic        soft_dma_reset,
   // Host port
   input  logic        prg_wrena,
   input  logic [7:0]  prg_addr,
   input  logic [31:0] prg_wrdata,
   output logic [31:0] prg_rddata,
   // Write direction table
   output logic [15:0] dt_size_wr,
   output logic [63:0] dt_base_rc_wr,
   output logic [15:0] dt_rc_last_wr,
   output logic        dt_rc_last_sync_wr,
   output logic        dt_eplast_ena_wr,
   output logic        dt_msi_wr,
   output logic        dt_3dw_rcadd_wr,
   output logic [4:0]  app_msi_num_wr,
   output logic [2:0]  app_msi_tc_wr,
   output logic        init_wr,
   // Read direction table
   output logic [15:0] dt_size_rd,
   output logic [63:0] dt_base_rc_rd,
   output logic [15:0] dt_rc_last_rd,
   output logic        dt_rc_last_sync_rd,
   output logic        dt_eplast_ena_rd,
   output logic        dt_msi_rd,
   output logic        dt_3dw_rcadd_rd,
   output logic [4:0]  app_msi_num_rd,
   output logic [2:0]  app_msi_tc_rd,
   output logic        init_rd
);

   logic        dir_rd;
   hdr_word_t   hdr_addr;
   logic [31:0] rddata_wr;
   logic [31:0] rddata_rd;
   // Direction bit delayed to line up with the table readback
   logic [1:0]  dir_pipe;

   assign dir_rd   = prg_addr[`DMA_DIR_BIT];
   assign hdr_addr = hdr_word_t'(prg_addr[3:2]);

   always_ff @(posedge clk_in) begin
      if (soft_dma_reset) begin
         dir_pipe <= '0;
      end else begin
         dir_pipe <= {dir_pipe[0], dir_rd};
      end
   end

   assign prg_rddata = dir_pipe[1] ? rddata_rd : rddata_wr;

   // ------------------------------------------------------------
   // Header tables
   // ------------------------------------------------------------
   dma_prg_reg u_prg_wr (
      .clk_in          (clk_in),
      .soft_dma_reset  (soft_dma_reset),
      .wrena           (prg_wrena & ~dir_rd),
      .addr            (hdr_addr),
      .wrdata          (prg_wrdata),
      .rddata          (rddata_wr),
      .dt_size         (dt_size_wr),
      .dt_base_rc      (dt_base_rc_wr),
      .dt_rc_last      (dt_rc_last_wr),
      .dt_rc_last_sync (dt_rc_last_sync_wr),
      .dt_eplast_ena   (dt_eplast_ena_wr),
      .dt_msi          (dt_msi_wr),
      .dt_3dw_rcadd    (dt_3dw_rcadd_wr),
      .app_msi_num     (app_msi_num_wr),
      .app_msi_tc      (app_msi_tc_wr),
      .init            (init_wr)
   );

   dma_prg_reg u_prg_rd (
      .clk_in          (clk_in),
      .soft_dma_reset  (soft_dma_reset),
      .wrena           (prg_wrena & dir_rd),
      .addr            (hdr_addr),
      .wrdata          (prg_wrdata),
      .rddata          (rddata_rd),
      .dt_size         (dt_size_rd),
      .dt_base_rc      (dt_base_rc_rd),
      .dt_rc_last      (dt_rc_last_rd),
      .dt_rc_last_sync (dt_rc_last_sync_rd),
      .dt_eplast_ena   (dt_eplast_ena_rd),
      .dt_msi          (dt_msi_rd),
      .dt_3dw_rcadd    (dt_3dw_rcadd_rd),
      .app_msi_num     (app_msi_num_rd),
      .app_msi_tc      (app_msi_tc_rd),
      .init            (init_rd)
   );

endmodule

`default_nettype wire

/* hw/dma_prg/dma_prg_reg.sv */
// Descriptor header table of one DMA direction, written by the host
// Registers the write, holds DW0..DW3 and derives the fields the walker uses
`timescale 1ns/1ps
`default_nettype none
`include "dma_chain_consts.svh"

module dma_prg_reg
   import dma_chain_pkg::*;
(
   input  logic        clk_in,
   input  logic        soft_dma_reset,
   // Host write port, already gated by direction
   input  logic        wrena,
   input  hdr_word_t   addr,
   input  logic [31:0] wrdata,
   output logic [31:0] rddata,
   // Derived header fields
   output logic [15:0] dt_size,
   output logic [63:0] dt_base_rc,
   output logic [15:0] dt_rc_last,
   output logic        dt_rc_last_sync,
   output logic        dt_eplast_ena,
   output logic        dt_msi,
   output logic        dt_3dw_rcadd,
   output logic [4:0]  app_msi_num,
   output logic [2:0]  app_msi_tc,
   output logic        init
);

   // Registered write stage
   logic        wrena_q;
   hdr_word_t   addr_q;
   logic [31:0] wrdata_q;

   // Table clear pulse and the init flag one stage ahead of the output
   logic        clear;
   logic        init_pre;

   // Header words as written by the host
   logic [31:0] hdr_dw0;
   logic [31:0] hdr_dw1;
   logic [31:0] hdr_dw2;
   logic [31:0] hdr_dw3;

   // ------------------------------------------------------------
   // Write stage
   // ------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset) begin
         wrena_q <= 1'b0;
      end else begin
         wrena_q <= wrena;
      end
   end

   // Address also feeds the readback, so it is captured every cycle
   always_ff @(posedge clk_in) begin
      addr_q   <= addr;
      wrdata_q <= wrdata;
   end

   // ------------------------------------------------------------
   // Clear and init
   // ------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset) begin
         clear    <= 1'b0;
         init_pre <= 1'b1;
         init     <= 1'b1;
      end else begin
         // All ones in the DW0 size field clears this table
         clear <= wrena_q && (addr_q == HDR_DW0) &&
                  (wrdata_q[15:0] == `DMA_CLEAR_PATTERN);
         // DW3 is written last, so it releases init
         if (clear) begin
            init_pre <= 1'b1;
         end else if (wrena_q && (addr_q == HDR_DW3)) begin
            init_pre <= 1'b0;
         end
         // Extra stage so init falls together with the derived fields
         init <= init_pre;
      end
   end

   // ------------------------------------------------------------
   // Header words
   // ------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset || clear) begin
         hdr_dw0 <= '0;
         hdr_dw1 <= '0;
         hdr_dw2 <= '0;
         hdr_dw3 <= '0;
      end else if (wrena_q) begin
         case (addr_q)
            HDR_DW0: hdr_dw0 <= wrdata_q;
            HDR_DW1: hdr_dw1 <= wrdata_q;
            HDR_DW2: hdr_dw2 <= wrdata_q;
            HDR_DW3: hdr_dw3 <= wrdata_q;
            default: hdr_dw0 <= hdr_dw0;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Derived fields, one edge behind the header words
   // ------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset || clear) begin
         dt_size         <= '0;
         dt_base_rc      <= '0;
         dt_rc_last      <= '0;
         dt_rc_last_sync <= 1'b0;
         dt_eplast_ena   <= 1'b0;
         dt_msi          <= 1'b0;
         // Upper base word is zero after a clear
         dt_3dw_rcadd    <= 1'b1;
         app_msi_num     <= '0;
         app_msi_tc      <= '0;
      end else begin
         // Last valid table index, so size minus one
         dt_size         <= hdr_dw0[15:0] - 16'd1;
         dt_msi          <= hdr_dw0[`DMA_DW0_MSI_BIT];
         dt_eplast_ena   <= hdr_dw0[`DMA_DW0_EPLAST_BIT];
         dt_rc_last_sync <= hdr_dw0[`DMA_DW0_SYNC_BIT];
         app_msi_num     <= hdr_dw0[`DMA_DW0_MSINUM_LSB +: 5];
         app_msi_tc      <= hdr_dw0[`DMA_DW0_TC_LSB +: 3];
         // DW1 is the upper half of the table base
         dt_base_rc      <= {hdr_dw1, hdr_dw2};
         dt_3dw_rcadd    <= (hdr_dw1 == 32'h0);
         dt_rc_last      <= hdr_dw3[15:0];
      end
   end

   // Readback of the word addressed in the write stage
   always_ff @(posedge clk_in) begin
      if (soft_dma_reset) begin
         rddata <= '0;
      end else begin
         case (addr_q)
            HDR_DW0: rddata <= hdr_dw0;
            HDR_DW1: rddata <= hdr_dw1;
            HDR_DW2: rddata <= hdr_dw2;
            default: rddata <= hdr_dw3;
         endcase
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module dma_chain_tb -Mdir obj_dir
output=$(./obj_dir/Vdma_chain_tb) || true
echo "$output"
if echo "$output" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi

/* sim/dma_chain_props.sv */
// Concurrent checks on the descriptor walker, bound into every walker instance
`timescale 1ns/1ps
`default_nettype none

module dma_chain_props
   import dma_chain_pkg::*;
(
   input logic        clk_in,
   input logic        soft_dma_reset,
   input walk_state_t state,
   input logic        desc_req,
   input logic        msi_req
);

   // One cycle per fetch request
   a_req_pulse: assert property (@(posedge clk_in) disable iff (soft_dma_reset)
      desc_req |=> !desc_req)
      else $error("desc_req high for more than one cycle");

   // Only one fetch outstanding
   a_no_req_in_wait: assert property (@(posedge clk_in) disable iff (soft_dma_reset)
      (state == WALK_WAIT) |-> !desc_req)
      else $error("desc_req while a fetch is outstanding");

   a_msi_in_report: assert property (@(posedge clk_in) disable iff (soft_dma_reset)
      msi_req |-> (state == WALK_REPORT))
      else $error("msi_req outside the report state");

endmodule

bind dma_desc_walker dma_chain_props u_props (
   .clk_in         (clk_in),
   .soft_dma_reset (soft_dma_reset),
   .state          (state),
   .desc_req       (desc_req),
   .msi_req        (msi_req)
);

`default_nettype wire

/* sim/dma_chain_tb.sv */
// Directed testbench for the chaining DMA control core
// Programs both header tables, answers fetches and checks the walker strobes
`timescale 1ns/1ps
`default_nettype none
`include "dma_chain_consts.svh"

module dma_chain_tb
   import dma_chain_pkg::*;
();

   logic        clk_in;
   logic        soft_dma_reset;
   logic        prg_wrena;
   logic [7:0]  prg_addr;
   logic [31:0] prg_wrdata;
   logic [31:0] prg_rddata;
   logic        init_wr;
   logic        init_rd;
   logic        dt_3dw_wr;
   logic        dt_3dw_rd;
   logic        desc_req_wr;
   logic [63:0] desc_addr_wr;
   logic        desc_done_wr;
   logic        eplast_upd_wr;
   logic [15:0] eplast_idx_wr;
   logic        msi_req_wr;
   logic [4:0]  msi_num_wr;
   logic [2:0]  msi_tc_wr;
   logic        desc_req_rd;
   logic [63:0] desc_addr_rd;
   logic        desc_done_rd;
   logic        eplast_upd_rd;
   logic [15:0] eplast_idx_rd;
   logic        msi_req_rd;
   logic [4:0]  msi_num_rd;
   logic [2:0]  msi_tc_rd;

   integer seed;
   int     errors;

   dma_chain_top u_dma_chain_top (.*);

   always #4 clk_in = ~clk_in;

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   // Bit 4 picks the table, bits 3:2 the header word
   function automatic logic [7:0] make_addr(input logic dir, input hdr_word_t w);
      return {3'b000, dir, w, 2'b00};
   endfunction

   function automatic logic [31:0] make_dw0(input logic [15:0] size, input logic eplast,
                                            input logic msi, input logic sync,
                                            input logic [4:0] num, input logic [2:0] tc);
      logic [31:0] w;
      w = 32'h0;
      w[15:0] = size;
      w[`DMA_DW0_EPLAST_BIT] = eplast;
      w[`DMA_DW0_MSI_BIT] = msi;
      w[`DMA_DW0_SYNC_BIT] = sync;
      w[`DMA_DW0_MSINUM_LSB +: 5] = num;
      w[`DMA_DW0_TC_LSB +: 3] = tc;
      return w;
   endfunction

   task automatic report_mismatch(input string what);
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out at %0t ns while waiting for %s", $time, what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped on timeout");
   endtask

   // ------------------------------------------------------------
   // Host tasks
   // ------------------------------------------------------------
   task automatic host_write(input logic dir, input hdr_word_t w, input logic [31:0] data);
      @(posedge clk_in);
      prg_wrena  <= 1'b1;
      prg_addr   <= make_addr(dir, w);
      prg_wrdata <= data;
      @(posedge clk_in);
      prg_wrena  <= 1'b0;
   endtask

   // Readback shows the word addressed two cycles earlier
   task automatic host_read_check(input logic dir, input hdr_word_t w,
                                  input logic [31:0] exp);
      @(posedge clk_in);
      prg_addr <= make_addr(dir, w);
      repeat (2) @(posedge clk_in);
      @(negedge clk_in);
      assert (prg_rddata == exp)
         else report_mismatch($sformatf("readback dir %0d word %0d got %h expected %h",
                                        dir, w, prg_rddata, exp));
   endtask

   task automatic wait_init(input logic dir, input logic value);
      logic seen;
      seen = 1'b0;
      for (int t = 0; t < 20 && !seen; t++) begin
         @(negedge clk_in);
         seen = ((dir ? init_rd : init_wr) == value);
      end
      if (!seen) report_timeout($sformatf("init of dir %0d to become %0d", dir, value));
   endtask

   // Strobes stay low for a number of cycles
   task automatic expect_quiet(input logic dir, input int cycles);
      repeat (cycles) begin
         @(negedge clk_in);
         assert (!(dir ? desc_req_rd : desc_req_wr))
            else report_mismatch($sformatf("unexpected fetch on dir %0d", dir));
         assert (!(dir ? eplast_upd_rd : eplast_upd_wr) && !(dir ? msi_req_rd : msi_req_wr))
            else report_mismatch($sformatf("unexpected eplast or MSI on dir %0d", dir));
      end
   endtask

   // Fetches for indexes first..first+count-1, each with its eplast update
   task automatic expect_fetches(input logic dir, input int first, input int count,
                                 input logic [63:0] base, input logic msi_on,
                                 input logic [4:0] num, input logic [2:0] tc);
      int          idx;
      logic        found;
      logic        last;
      logic [63:0] exp_addr;
      for (int n = 0; n < count; n++) begin
         idx      = first + n;
         last     = (n == count - 1);
         exp_addr = base + 64'(idx) * 64'(`DMA_DESC_BYTES);
         found    = 1'b0;
         for (int t = 0; t < 100 && !found; t++) begin
            @(negedge clk_in);
            found = dir ? desc_req_rd : desc_req_wr;
         end
         if (!found) report_timeout($sformatf("fetch of index %0d on dir %0d", idx, dir));
         assert ((dir ? desc_addr_rd : desc_addr_wr) == exp_addr)
            else report_mismatch($sformatf("fetch address for index %0d expected %h",
                                           idx, exp_addr));
         found = 1'b0;
         for (int t = 0; t < 100 && !found; t++) begin
            @(negedge clk_in);
            found = dir ? eplast_upd_rd : eplast_upd_wr;
         end
         if (!found) report_timeout($sformatf("eplast update of index %0d", idx));
         assert ((dir ? eplast_idx_rd : eplast_idx_wr) == 16'(idx))
            else report_mismatch($sformatf("eplast index expected %0d", idx));
         // MSI rides in the same report cycle as the last eplast update
         assert ((dir ? msi_req_rd : msi_req_wr) == (last && msi_on))
            else report_mismatch($sformatf("MSI strobe wrong at index %0d", idx));
         if (last && msi_on) begin
            assert ((dir ? msi_num_rd : msi_num_wr) == num && (dir ? msi_tc_rd : msi_tc_wr) == tc)
               else report_mismatch("MSI number or traffic class wrong");
         end
      end
      expect_quiet(dir, 30);
   endtask

   task automatic clear_table(input logic dir);
      host_write(dir, HDR_DW0, {16'h0, `DMA_CLEAR_PATTERN});
      wait_init(dir, 1'b1);
      assert ((dir ? dt_3dw_rd : dt_3dw_wr) == 1'b1)
         else report_mismatch("3DW flag not set after clear");
      host_read_check(dir, HDR_DW0, 32'h0);
      host_read_check(dir, HDR_DW1, 32'h0);
      host_read_check(dir, HDR_DW2, 32'h0);
      host_read_check(dir, HDR_DW3, 32'h0);
   endtask

   // ------------------------------------------------------------
   // Fetch responders, random back-pressure
   // ------------------------------------------------------------
   always @(negedge clk_in) begin : answer_wr
      int unsigned delay;
      if (desc_req_wr) begin
         delay = unsigned'($random(seed)) % 5;
         @(posedge clk_in);
         repeat (delay) @(posedge clk_in);
         desc_done_wr <= 1'b1;
         @(posedge clk_in);
         desc_done_wr <= 1'b0;
      end
   end

   always @(negedge clk_in) begin : answer_rd
      int unsigned delay;
      if (desc_req_rd) begin
         delay = unsigned'($random(seed)) % 5;
         @(posedge clk_in);
         repeat (delay) @(posedge clk_in);
         desc_done_rd <= 1'b1;
         @(posedge clk_in);
         desc_done_rd <= 1'b0;
      end
   end

   initial begin : watchdog
      repeat (20000) @(posedge clk_in);
      $display("Watchdog expired, the test sequence did not finish");
      $display("SIMULATION FAILED");
      $fatal(1, "stopped by watchdog");
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      seed           = 32'h7459;
      errors         = 0;
      clk_in         = 1'b0;
      soft_dma_reset = 1'b1;
      prg_wrena      = 1'b0;
      prg_addr       = 8'h0;
      prg_wrdata     = 32'h0;
      desc_done_wr   = 1'b0;
      desc_done_rd   = 1'b0;
      repeat (3) @(posedge clk_in);
      soft_dma_reset <= 1'b0;

      // Reset state
      @(negedge clk_in);
      assert (init_wr && init_rd) else report_mismatch("init not high after reset");
      expect_quiet(1'b0, 10);
      expect_quiet(1'b1, 10);
      for (int a = 0; a < 8; a++) begin
         host_read_check(a[2], hdr_word_t'(a[1:0]), 32'h0);
      end

      // Readback and decode, short walks with eplast only
      host_write(1'b0, HDR_DW0, 32'h0534_0010);
      host_write(1'b0, HDR_DW1, 32'h0000_00A1);
      host_write(1'b0, HDR_DW2, 32'h4000_1000);
      host_write(1'b0, HDR_DW3, 32'h0000_0002);
      expect_fetches(1'b0, 0, 3, 64'h0000_00A1_4000_1000, 1'b0, 5'd0, 3'd0);
      host_write(1'b1, HDR_DW0, 32'h2644_0020);
      host_write(1'b1, HDR_DW1, 32'h0000_00B2);
      host_write(1'b1, HDR_DW2, 32'h5000_2000);
      host_write(1'b1, HDR_DW3, 32'h0000_0001);
      expect_fetches(1'b1, 0, 2, 64'h0000_00B2_5000_2000, 1'b0, 5'd0, 3'd0);
      host_read_check(1'b0, HDR_DW0, 32'h0534_0010);
      host_read_check(1'b0, HDR_DW1, 32'h0000_00A1);
      host_read_check(1'b0, HDR_DW2, 32'h4000_1000);
      host_read_check(1'b0, HDR_DW3, 32'h0000_0002);
      host_read_check(1'b1, HDR_DW0, 32'h2644_0020);
      host_read_check(1'b1, HDR_DW1, 32'h0000_00B2);
      host_read_check(1'b1, HDR_DW2, 32'h5000_2000);
      host_read_check(1'b1, HDR_DW3, 32'h0000_0001);
      assert (!dt_3dw_wr && !dt_3dw_rd) else report_mismatch("3DW set with nonzero DW1");
      clear_table(1'b0);
      clear_table(1'b1);

      // Descriptor walk, MSI enabled on both tables with their own number and class
      host_write(1'b0, HDR_DW0, make_dw0(16'd8, 1'b1, 1'b1, 1'b0, 5'd5, 3'd3));
      host_write(1'b0, HDR_DW1, 32'h0);
      host_write(1'b0, HDR_DW2, 32'h1000_0000);
      host_write(1'b0, HDR_DW3, 32'd3);
      expect_fetches(1'b0, 0, 4, 64'h1000_0000, 1'b1, 5'd5, 3'd3);
      assert (dt_3dw_wr && !init_wr) else report_mismatch("write table status wrong");
      host_write(1'b1, HDR_DW0, make_dw0(16'd8, 1'b1, 1'b1, 1'b0, 5'd9, 3'd2));
      host_write(1'b1, HDR_DW1, 32'h2);
      host_write(1'b1, HDR_DW2, 32'h2000_0000);
      host_write(1'b1, HDR_DW3, 32'd3);
      expect_fetches(1'b1, 0, 4, 64'h2_2000_0000, 1'b1, 5'd9, 3'd2);
      assert (!dt_3dw_rd) else report_mismatch("3DW set on read table");

      // Chaining, continue then wrap only with sync
      host_write(1'b0, HDR_DW3, 32'd6);
      expect_fetches(1'b0, 4, 3, 64'h1000_0000, 1'b1, 5'd5, 3'd3);
      host_write(1'b0, HDR_DW3, 32'd1);
      expect_quiet(1'b0, 40);
      host_write(1'b0, HDR_DW3, 32'd6);
      expect_quiet(1'b0, 40);
      host_write(1'b0, HDR_DW0, make_dw0(16'd8, 1'b1, 1'b1, 1'b1, 5'd5, 3'd3));
      host_write(1'b0, HDR_DW3, 32'd1);
      expect_fetches(1'b0, 0, 2, 64'h1000_0000, 1'b1, 5'd5, 3'd3);

      // Clear of the write table leaves the read table running
      clear_table(1'b0);
      assert (!init_rd) else report_mismatch("read table init raised by write clear");
      host_read_check(1'b1, HDR_DW0, make_dw0(16'd8, 1'b1, 1'b1, 1'b0, 5'd9, 3'd2));
      host_read_check(1'b1, HDR_DW3, 32'd3);
      expect_quiet(1'b0, 20);
      host_write(1'b1, HDR_DW3, 32'd5);
      expect_fetches(1'b1, 4, 2, 64'h2_2000_0000, 1'b1, 5'd9, 3'd2);
      expect_quiet(1'b0, 10);

      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
